// ==== mipsPkg.sv ====
package mipsPkg;

    // register-format fields
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFields;

    // immediate-format fields whose low 26 bits double as jump index
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFields;

    typedef union packed {
        rFields rView;
        iFields iView;
    } instrWord;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui
    } aluOp;

    // what decode hands down the pipe
    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrcImm;
        logic regDstRd;
        logic signExt;
        logic branch;
        logic branchNe;
        logic jump;
        aluOp alu;
    } ctrlSig;

    typedef enum logic [1:0] {
        fromReg,
        fromMem,
        fromWb
    } fwdSel;

    typedef enum logic [1:0] {
        seqPc,
        predTarget,
        jumpTarget,
        repairPc
    } pcSel;

    typedef struct packed {
        logic [4:0] rsE;
        logic [4:0] rtE;
        logic [4:0] writeRegM;
        logic       regWriteM;
        logic [4:0] writeRegW;
        logic       regWriteW;
        logic       branchD;
        logic       predTakeD;
        logic       jumpD;
        logic       mispredictM;
    } hazardView;

    typedef struct packed {
        fwdSel fwdA;
        fwdSel fwdB;
        logic  stallAll;
        logic  flushD;
        logic  flushE;
        pcSel  nextPc;
    } hazardCtrl;

endpackage

// ==== controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
    input  mipsPkg::instrWord instr,
    output mipsPkg::ctrlSig   ctrl
);
    import mipsPkg::*;

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    always_comb begin
        ctrl = '0;
        case (instr.iView.op)
            opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (instr.rView.funct)
                    fnAddu:  ctrl.alu = aluAdd;
                    fnSubu:  ctrl.alu = aluSub;
                    fnAnd:   ctrl.alu = aluAnd;
                    fnOr:    ctrl.alu = aluOr;
                    fnSlt:   ctrl.alu = aluSlt;
                    // unknown funct falls back to a no-op
                    default: ctrl = '0;
                endcase
            end
            opAddiu, opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt   = 1'b1;
                ctrl.memRead   = (instr.iView.op == opLw);
                ctrl.memToReg  = (instr.iView.op == opLw);
            end
            opOri, opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.alu       = (instr.iView.op == opLui) ? aluLui : aluOr;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt   = 1'b1;
            end
            opBeq, opBne: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = (instr.iView.op == opBne);
                ctrl.signExt  = 1'b1;
                ctrl.alu      = aluSub;
            end
            opJ: begin
                ctrl.jump = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
    input  logic               clk,
    input  logic               rst,
    input  mipsPkg::hazardView view,
    input  logic               dCacheStall,
    output mipsPkg::hazardCtrl hctl
);
    import mipsPkg::*;

    logic repairIssued;
    logic repairNow;
    logic predRedirect;

    // memory stage wins over write-back
    function automatic fwdSel pickSrc(input logic [4:0] src, input hazardView v);
        if (v.regWriteM && v.writeRegM != 5'd0 && v.writeRegM == src) begin
            return fromMem;
        end else if (v.regWriteW && v.writeRegW != 5'd0 && v.writeRegW == src) begin
            return fromWb;
        end
        return fromReg;
    endfunction

    // a branch that sat in memory through a stall is repaired once, on release
    assign repairNow = view.mispredictM & ~repairIssued & ~dCacheStall;
    assign predRedirect = ~dCacheStall & view.branchD & view.predTakeD;

    always_ff @(posedge clk) begin
        if (rst) begin
            repairIssued <= 1'b0;
        end else if (!dCacheStall) begin
            repairIssued <= repairNow;
        end
    end

    always_comb begin
        hctl.fwdA     = pickSrc(view.rsE, view);
        hctl.fwdB     = pickSrc(view.rtE, view);
        hctl.stallAll = dCacheStall;
        hctl.flushE   = repairNow;
        hctl.flushD   = repairNow | predRedirect | (~dCacheStall & view.jumpD);
        if (repairNow) begin
            hctl.nextPc = repairPc;
        end else if (!dCacheStall && view.jumpD) begin
            hctl.nextPc = jumpTarget;
        end else if (predRedirect) begin
            hctl.nextPc = predTarget;
        end else begin
            hctl.nextPc = seqPc;
        end
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/100ps

module datapath #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst,
    output logic [31:0]        instAddr,
    output logic               instEn,
    input  logic [31:0]        instr,
    output logic               memEn,
    output logic [31:0]        memAddr,
    output logic [3:0]         memWen,
    output logic [31:0]        memWdata,
    input  logic [31:0]        memRdata,
    output mipsPkg::instrWord  instrD,
    input  mipsPkg::ctrlSig    ctrlD,
    output mipsPkg::hazardView view,
    input  mipsPkg::hazardCtrl hctl
);
    import mipsPkg::*;

    logic [31:0] pcF, pcPlus4F, pcNext;
    logic        validD, branchD, predTakeD;
    ctrlSig      ctrlDv;
    logic [31:0] pcPlus4D, immD, rdAD, rdBD, targetD, jumpAddrD, repairD;
    logic        validE, predTakeE, takenE;
    ctrlSig      ctrlE;
    logic [31:0] rdAE, rdBE, immE, repairE;
    logic [4:0]  rsE, rtE, rdE, writeRegE;
    logic [31:0] srcA, rtVal, srcB, aluOut;
    logic        validM, predTakeM, takenM, regWriteM;
    ctrlSig      ctrlM;
    logic [31:0] aluOutM, storeDataM, repairM, resultM;
    logic [4:0]  writeRegM;
    logic        validW, regWriteW;
    logic [4:0]  writeRegW;
    logic [31:0] resultW;
    logic [31:0] regFile [32];
    logic        rfWe;

    function automatic logic [31:0] fwdMux(input fwdSel sel, input logic [31:0] regVal,
                                           input logic [31:0] memVal, input logic [31:0] wbVal);
        case (sel)
            fromMem: return memVal;
            fromWb:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign pcPlus4F = pcF + 32'd4;
    always_comb begin
        case (hctl.nextPc)
            predTarget: pcNext = targetD;
            jumpTarget: pcNext = jumpAddrD;
            repairPc:   pcNext = repairM;
            default:    pcNext = pcPlus4F;
        endcase
    end
    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= resetPc;
        end else if (!hctl.stallAll) begin
            pcF <= pcNext;
        end
    end
    assign instAddr = pcF;
    assign instEn   = ~hctl.stallAll;

    always_ff @(posedge clk) begin
        if (rst) begin
            validD <= 1'b0;
            validE <= 1'b0;
            validM <= 1'b0;
            validW <= 1'b0;
        end else if (!hctl.stallAll) begin
            validD <= ~hctl.flushD;
            validE <= validD & ~hctl.flushE;
            validM <= validE & ~hctl.flushE;
            validW <= validM;
        end
    end

    always_ff @(posedge clk) begin
        if (!hctl.stallAll) begin
            instrD     <= instr;
            pcPlus4D   <= pcPlus4F;
            ctrlE      <= ctrlDv;
            rdAE       <= rdAD;
            rdBE       <= rdBD;
            immE       <= immD;
            rsE        <= instrD.rView.rs;
            rtE        <= instrD.rView.rt;
            rdE        <= instrD.rView.rd;
            predTakeE  <= predTakeD;
            repairE    <= repairD;
            ctrlM      <= ctrlE;
            aluOutM    <= aluOut;
            storeDataM <= rtVal;
            writeRegM  <= writeRegE;
            predTakeM  <= predTakeE;
            takenM     <= takenE;
            repairM    <= repairE;
            regWriteW  <= ctrlM.regWrite;
            writeRegW  <= writeRegM;
            resultW    <= resultM;
        end
    end

    // decode
    assign ctrlDv = validD ? ctrlD : '0;
    assign immD = ctrlDv.signExt ? {{16{instrD.iView.imm16[15]}}, instrD.iView.imm16}
                                 : {16'h0000, instrD.iView.imm16};
    assign targetD   = pcPlus4D + {immD[29:0], 2'b00};
    assign jumpAddrD = {pcPlus4D[31:28], instrD.iView[25:0], 2'b00};
    assign branchD   = ctrlDv.branch;
    // backward branches predicted taken
    assign predTakeD = branchD & instrD.iView.imm16[15];
    assign repairD   = predTakeD ? pcPlus4D : targetD;

    // register file written from the memory stage
    assign rfWe = regWriteM & ~hctl.stallAll & (writeRegM != 5'd0);
    always_ff @(posedge clk) begin
        if (rfWe) begin
            regFile[writeRegM] <= resultM;
        end
    end
    assign rdAD = (instrD.iView.rs == 5'd0) ? 32'd0 :
                  (rfWe && writeRegM == instrD.iView.rs) ? resultM : regFile[instrD.iView.rs];
    assign rdBD = (instrD.iView.rt == 5'd0) ? 32'd0 :
                  (rfWe && writeRegM == instrD.iView.rt) ? resultM : regFile[instrD.iView.rt];

    // execute
    assign srcA  = fwdMux(hctl.fwdA, rdAE, resultM, resultW);
    assign rtVal = fwdMux(hctl.fwdB, rdBE, resultM, resultW);
    assign srcB  = ctrlE.aluSrcImm ? immE : rtVal;
    always_comb begin
        case (ctrlE.alu)
            aluAdd:  aluOut = srcA + srcB;
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
            aluLui:  aluOut = {srcB[15:0], 16'h0000};
            default: aluOut = 32'd0;
        endcase
    end
    assign takenE    = validE & ctrlE.branch & (ctrlE.branchNe ^ (srcA == rtVal));
    assign writeRegE = ctrlE.regDstRd ? rdE : rtE;

    // memory
    assign memEn     = validM & (ctrlM.memRead | ctrlM.memWrite);
    assign memWen    = {4{validM & ctrlM.memWrite}};
    assign memAddr   = aluOutM;
    assign memWdata  = storeDataM;
    assign resultM   = ctrlM.memToReg ? memRdata : aluOutM;
    assign regWriteM = validM & ctrlM.regWrite;

    always_comb begin
        view.rsE         = rsE;
        view.rtE         = rtE;
        view.writeRegM   = writeRegM;
        view.regWriteM   = regWriteM;
        view.writeRegW   = writeRegW;
        view.regWriteW   = validW & regWriteW;
        view.branchD     = branchD;
        view.predTakeD   = predTakeD;
        view.jumpD       = ctrlDv.jump;
        view.mispredictM = validM & ctrlM.branch & (predTakeM ^ takenM);
    end

endmodule

// ==== mipsCore.sv ====
`timescale 1ns/100ps

module mipsCore #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] instAddr,
    output logic        instEn,
    input  logic [31:0] instr,
    output logic        memEn,
    output logic [31:0] memAddr,
    output logic [3:0]  memWen,
    output logic [31:0] memWdata,
    input  logic [31:0] memRdata,
    input  logic        dCacheStall
);
    import mipsPkg::*;

    instrWord  instrD;
    ctrlSig    ctrlD;
    hazardView view;
    hazardCtrl hctl;

    controlUnit uControl (
        .instr (instrD),
        .ctrl  (ctrlD)
    );

    hazardUnit uHazard (
        .clk         (clk),
        .rst         (rst),
        .view        (view),
        .dCacheStall (dCacheStall),
        .hctl        (hctl)
    );

    datapath #(
        .resetPc (resetPc)
    ) uDatapath (
        .clk      (clk),
        .rst      (rst),
        .instAddr (instAddr),
        .instEn   (instEn),
        .instr    (instr),
        .memEn    (memEn),
        .memAddr  (memAddr),
        .memWen   (memWen),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .instrD   (instrD),
        .ctrlD    (ctrlD),
        .view     (view),
        .hctl     (hctl)
    );

endmodule

// ==== mipsCore_chk.sv ====
`timescale 1ns/100ps

module mipsCoreChk #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input logic        clk,
    input logic        rst,
    input logic [31:0] instAddr,
    input logic        instEn,
    input logic        memEn,
    input logic [31:0] memAddr,
    input logic [3:0]  memWen,
    input logic [31:0] memWdata,
    input logic        dCacheStall
);

    localparam logic [31:0] poisonAddr = 32'h000d_ead0;

    int errCount = 0;

    // pipe holds only bubbles after a reset edge
    rstQuiet: assert property (@(posedge clk) rst |=> (!memEn && memWen == 4'b0000))
        else begin
            errCount++;
            $error("memory strobes active after a reset cycle");
        end

    firstFetch: assert property (@(posedge clk) $fell(rst) |-> (instAddr == resetPc && instEn))
        else begin
            errCount++;
            $error("first fetch after reset is not at the reset address");
        end

    // the stalled access is presented again unchanged
    stallHold: assert property (@(posedge clk) disable iff (rst)
        dCacheStall |=> ($stable(memEn) && $stable(memAddr) && $stable(memWen)
                         && $stable(memWdata)))
        else begin
            errCount++;
            $error("memory port changed while the data cache stalled");
        end

    fetchOff: assert property (@(posedge clk) disable iff (rst) dCacheStall |-> !instEn)
        else begin
            errCount++;
            $error("fetch enabled during a data cache stall");
        end

    // squashed stores aim here
    noPoison: assert property (@(posedge clk) disable iff (rst)
        (memEn && memWen != 4'b0000) |-> memAddr != poisonAddr)
        else begin
            errCount++;
            $error("a squashed store reached the memory port");
        end

endmodule

bind mipsCore mipsCoreChk #(
    .resetPc (resetPc)
) uChk (
    .clk         (clk),
    .rst         (rst),
    .instAddr    (instAddr),
    .instEn      (instEn),
    .memEn       (memEn),
    .memAddr     (memAddr),
    .memWen      (memWen),
    .memWdata    (memWdata),
    .dCacheStall (dCacheStall)
);

// ==== tbMipsCore.sv ====
`timescale 1ns/100ps

module tbMipsCore;

    localparam int clkPeriod = 8;
    localparam int progLen   = 40;
    localparam logic [31:0] resetPc = 32'h0000_0000;

    localparam int opJ     = 'h02;
    localparam int opBeq   = 'h04;
    localparam int opBne   = 'h05;
    localparam int opAddiu = 'h09;
    localparam int opOri   = 'h0d;
    localparam int opLui   = 'h0f;
    localparam int opLw    = 'h23;
    localparam int opSw    = 'h2b;
    localparam int fnAddu  = 'h21;
    localparam int fnSubu  = 'h23;
    localparam int fnAnd   = 'h24;
    localparam int fnOr    = 'h25;
    localparam int fnSlt   = 'h2a;

    logic        clk;
    logic        rst = 1'b1;
    logic [31:0] instAddr;
    logic        instEn;
    logic [31:0] instr;
    logic        memEn;
    logic [31:0] memAddr;
    logic [3:0]  memWen;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic        dCacheStall = 1'b0;

    logic [31:0] rom [64];
    logic [31:0] ram [256];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    string       expMark [$];

    integer seed;
    int     storeIdx = 0;
    int     tbErrors = 0;
    int     stallCycles = 0;
    int     testsRun = 0;
    int     testsFailed = 0;
    int     errorsAtLastTest = 0;

    mipsCore #(
        .resetPc (resetPc)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .instAddr    (instAddr),
        .instEn      (instEn),
        .instr       (instr),
        .memEn       (memEn),
        .memAddr     (memAddr),
        .memWen      (memWen),
        .memWdata    (memWdata),
        .memRdata    (memRdata),
        .dCacheStall (dCacheStall)
    );

    function automatic logic [31:0] encR(input int funct, input int rd,
                                         input int rs, input int rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct[5:0]};
    endfunction

    function automatic logic [31:0] encI(input int op, input int rt, input int rs, input int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] encJ(input int wordIdx);
        return {opJ[5:0], wordIdx[25:0]};
    endfunction

    function automatic int totalErrors();
        return tbErrors + DUT.uChk.errCount;
    endfunction

    task automatic loadProgram();
        // arithmetic chain forwarded from memory and write-back
        rom[0]  = encI(opAddiu, 1, 0, 5);
        rom[1]  = encI(opAddiu, 2, 1, 3);
        rom[2]  = encR(fnAddu, 3, 2, 1);
        rom[3]  = encR(fnSubu, 4, 3, 2);
        rom[4]  = encR(fnSlt, 5, 4, 3);
        rom[5]  = encI(opLui, 6, 0, 'h1234);
        rom[6]  = encI(opOri, 6, 6, 'h5678);
        rom[7]  = encR(fnAnd, 7, 6, 3);
        rom[8]  = encR(fnOr, 8, 7, 4);
        rom[9]  = encI(opSw, 3, 0, 'h100);
        rom[10] = encI(opSw, 5, 0, 'h104);
        rom[11] = encI(opSw, 6, 0, 'h108);
        rom[12] = encI(opSw, 8, 0, 'h10c);
        // load then immediate use
        rom[13] = encI(opLw, 9, 0, 'h40);
        rom[14] = encI(opAddiu, 10, 9, 1);
        rom[15] = encI(opSw, 10, 0, 'h110);
        // four passes with bne back to word 19
        rom[16] = encI(opAddiu, 11, 0, 4);
        rom[17] = encI(opAddiu, 12, 0, 0);
        rom[18] = encI(opAddiu, 13, 0, 'h200);
        rom[19] = encI(opAddiu, 12, 12, 3);
        rom[20] = encI(opSw, 12, 13, 0);
        rom[21] = encI(opAddiu, 13, 13, 4);
        rom[22] = encI(opAddiu, 11, 11, -1);
        rom[23] = encI(opBne, 0, 11, -5);
        rom[24] = encI(opSw, 12, 0, 'h230);
        // forward beq taken to word 33 skips words 30..32
        rom[25] = encI(opAddiu, 14, 0, 7);
        rom[26] = encI(opAddiu, 15, 0, 7);
        rom[27] = encI(opLui, 20, 0, 'h000d);
        rom[28] = encI(opOri, 20, 20, 'head0);
        rom[29] = encI(opBeq, 15, 14, 3);
        rom[30] = encI(opSw, 14, 20, 0);
        rom[31] = encI(opSw, 15, 20, 0);
        rom[32] = encI(opSw, 14, 20, 0);
        rom[33] = encI(opAddiu, 16, 14, 'h10);
        rom[34] = encJ(37);
        rom[35] = encI(opSw, 16, 20, 0);
        rom[36] = encI(opSw, 16, 20, 0);
        rom[37] = encI(opSw, 16, 0, 'h300);
        // spin here
        rom[38] = encJ(38);
        rom[39] = encJ(38);
    endtask

    task automatic addExpected(input logic [31:0] addr, input logic [31:0] data,
                               input string mark);
        expAddr.push_back(addr);
        expData.push_back(data);
        expMark.push_back(mark);
    endtask

    task automatic loadExpected();
        addExpected(32'h100, 32'd13, "");
        addExpected(32'h104, 32'd1, "");
        addExpected(32'h108, 32'h1234_5678, "");
        addExpected(32'h10c, 32'd13, "");
        // ram fill at 0x40 plus one
        addExpected(32'h110, 32'hc0de_0041, "arith and load-use forwarding");
        addExpected(32'h200, 32'd3, "");
        addExpected(32'h204, 32'd6, "");
        addExpected(32'h208, 32'd9, "");
        addExpected(32'h20c, 32'd12, "");
        addExpected(32'h230, 32'd12, "backward bne loop");
        addExpected(32'h300, 32'h17, "forward beq and jump");
    endtask

    task automatic finishTest(input string name);
        int newErrors;
        newErrors = totalErrors() - errorsAtLastTest;
        errorsAtLastTest = totalErrors();
        testsRun++;
        if (newErrors == 0) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, newErrors);
        end
    endtask

    task automatic checkStore();
        string mark;
        assert (storeIdx < expAddr.size()) else begin
            tbErrors++;
            $display("ERROR: unexpected extra store to %08h at time %0t", memAddr, $time);
        end
        if (storeIdx < expAddr.size()) begin
            assert (memAddr == expAddr[storeIdx]) else begin
                tbErrors++;
                $display("FAIL time %0t memAddr expected %08h actual %08h",
                         $time, expAddr[storeIdx], memAddr);
            end
            assert (memWdata == expData[storeIdx]) else begin
                tbErrors++;
                $display("FAIL time %0t memWdata expected %08h actual %08h",
                         $time, expData[storeIdx], memWdata);
            end
            assert (memWen == 4'b1111) else begin
                tbErrors++;
                $display("FAIL time %0t memWen expected 1111 actual %04b", $time, memWen);
            end
            mark = expMark[storeIdx];
            storeIdx++;
            if (mark != "") begin
                finishTest(mark);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // instruction and data come back in the same cycle
    assign instr    = rom[instAddr[7:2]];
    assign memRdata = memEn ? ram[memAddr[9:2]] : 32'h0000_0000;

    always @(posedge clk) begin
        if (memEn && memWen != 4'b0000 && !dCacheStall) begin
            ram[memAddr[9:2]] <= memWdata;
        end
    end

    // a store counts once on its unstalled cycle
    always @(negedge clk) begin
        if (!rst && memEn && memWen != 4'b0000 && !dCacheStall) begin
            checkStore();
        end
    end

    initial begin
        seed = 32'ha857_554f;
        wait (!rst);
        forever begin
            @(posedge clk);
            #1;
            dCacheStall = ({$random(seed)} % 5) == 0;
            if (dCacheStall) begin
                stallCycles++;
            end
        end
    end

    initial begin
        #(progLen * 8 * clkPeriod);
        $display("ERROR: watchdog expired at %0t with %0d of %0d stores seen",
                 $time, storeIdx, expAddr.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] <= 32'hc0de_0000 | (i << 2);
        end
        loadProgram();
        loadExpected();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        finishTest("reset state");
        wait (storeIdx == expAddr.size());
        repeat (20) @(posedge clk);
        finishTest($sformatf("dcache stall, %0d stall cycles", stallCycles));
        $display("summary: %0d tests, %0d failed, %0d of %0d stores checked, %0d errors",
                 testsRun, testsFailed, storeIdx, expAddr.size(), totalErrors());
        if (totalErrors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
mipsPkg.sv
controlUnit.sv
hazardUnit.sv
datapath.sv
mipsCore.sv
mipsCore_chk.sv
tbMipsCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbMipsCore
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIMARGS   ?= +verilator+error+limit+1000
PASSMSG   ?= Test passed

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
